// ==== hw/bus_probe_pkg.sv ====
package bus_probe_pkg;

	localparam int SAMPLE_W   = 30;
	localparam int NUM_ROUTES = 6;
	localparam int REC_ADDR_W = 10;

	// addr, rom, data, xram, rd, wr, phi, reset, aux from bit 0 up.
	typedef logic [SAMPLE_W-1:0]   sample_t;
	typedef logic [NUM_ROUTES-1:0] route_t;
	typedef logic [REC_ADDR_W-1:0] rec_addr_t;
	typedef logic [31:0]           rec_word_t;
	typedef logic [31:0]           atom_t;
	typedef logic [7:0]            byte_t;
	typedef logic [11:0]           reg_addr_t;

	localparam reg_addr_t ADDR_REC_RAM   = 12'h000;
	localparam reg_addr_t ADDR_REG_BASE  = 12'hF00;
	localparam reg_addr_t ADDR_ATOM      = 12'hF10;
	localparam reg_addr_t ADDR_ONES      = 12'hF14;
	localparam reg_addr_t ADDR_REC_CTL   = 12'hF15;
	localparam reg_addr_t ADDR_REC_CFG   = 12'hF16;
	localparam reg_addr_t ADDR_REC_STAT  = 12'hF17;
	localparam reg_addr_t ADDR_REC_ADR   = 12'hF18;
	localparam reg_addr_t ADDR_CMP_VAL   = 12'hF20;
	localparam reg_addr_t ADDR_CMP_ROUTE = 12'hF21;
	localparam reg_addr_t ADDR_SAMPLE    = 12'hF50;

	typedef enum logic {REC_IDLE, REC_RUNNING} rec_state_t;

endpackage

// ==== hw/trig_cfg_if.sv ====
`timescale 1ns/1ps

interface trig_cfg_if #(
	parameter int NUM_COMPARATORS = 2
);
	import bus_probe_pkg::*;

	sample_t [NUM_COMPARATORS-1:0] cmp_val;
	sample_t [NUM_COMPARATORS-1:0] cmp_mask;
	route_t  [NUM_COMPARATORS-1:0] lvl_route;
	route_t  [NUM_COMPARATORS-1:0] edge_route;
	route_t                        ones;

	modport cfg (output cmp_val, cmp_mask, lvl_route, edge_route, ones);
	modport trig (input cmp_val, cmp_mask, lvl_route, edge_route, ones);

endinterface

// ==== hw/rec_ctrl_if.sv ====
`timescale 1ns/1ps

interface rec_ctrl_if;
	import bus_probe_pkg::*;

	route_t    start_routes;
	route_t    stop_routes;
	route_t    cap_routes;
	logic      start_now;
	logic      stop_now;
	logic      cap_now;
	logic      cyclic;
	logic      addr_load;
	rec_addr_t addr_val;
	rec_addr_t rd_idx;
	logic      running;
	rec_addr_t addr;
	rec_word_t rd_word;

	modport cfg (
		output start_routes, stop_routes, cap_routes, start_now, stop_now, cap_now,
		output cyclic, addr_load, addr_val, rd_idx,
		input  running, addr, rd_word
	);

	modport rec (
		input  start_routes, stop_routes, cap_routes, start_now, stop_now, cap_now,
		input  cyclic, addr_load, addr_val, rd_idx,
		output running, addr, rd_word
	);

endinterface

// ==== hw/bus_sampler.sv ====
`timescale 1ns/1ps

module bus_sampler (
	input  logic                   pllclk,
	input  logic                   f_reset,
	input  logic [14:0]            dut_adr,
	input  logic [7:0]             dut_data,
	input  logic                   n_rd,
	input  logic                   n_wr,
	input  logic                   n_cs_rom,
	input  logic                   n_cs_xram,
	input  logic                   phi,
	input  logic                   n_reset,
	input  logic                   aux_in,
	output bus_probe_pkg::sample_t sample
);
	import bus_probe_pkg::*;

	sample_t pin_raw;
	sample_t pin_meta;
	sample_t pin_sync;

	// strobes flipped to active high before the first stage.
	assign pin_raw = {aux_in, ~n_reset, phi, ~n_wr, ~n_rd, ~n_cs_xram,
	                  dut_data, ~n_cs_rom, dut_adr};

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			pin_meta <= '0;
			pin_sync <= '0;
		end else begin
			pin_meta <= pin_raw;
			pin_sync <= pin_meta;
		end
	end

	assign sample = pin_sync;

endmodule

// ==== hw/trigger_unit.sv ====
`timescale 1ns/1ps

module trigger_unit #(
	parameter int NUM_COMPARATORS = 2
) (
	input  logic                   pllclk,
	input  logic                   f_reset,
	input  bus_probe_pkg::sample_t sample,
	trig_cfg_if.trig               cfg,
	output bus_probe_pkg::route_t  route
);
	import bus_probe_pkg::*;

	logic [NUM_COMPARATORS-1:0] match;
	logic [NUM_COMPARATORS-1:0] prev_match;
	route_t                     route_next;

	always_comb begin
		route_next = cfg.ones;
		for (int i = 0; i < NUM_COMPARATORS; i++) begin
			match[i] = (sample & cfg.cmp_mask[i]) == (cfg.cmp_val[i] & cfg.cmp_mask[i]);
			if (match[i]) begin
				route_next |= cfg.lvl_route[i];
				// edge routes fire only on the first matching sample.
				if (!prev_match[i])
					route_next |= cfg.edge_route[i];
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			route      <= '0;
			prev_match <= '0;
		end else begin
			route      <= route_next;
			prev_match <= match;
		end
	end

endmodule

// ==== hw/recorder.sv ====
`timescale 1ns/1ps

module recorder (
	input  logic                   pllclk,
	input  logic                   f_reset,
	input  bus_probe_pkg::sample_t sample,
	input  bus_probe_pkg::route_t  route,
	rec_ctrl_if.rec                ctl
);
	import bus_probe_pkg::*;

	localparam int REC_DEPTH = 1 << REC_ADDR_W;

	rec_word_t  mem [REC_DEPTH];
	rec_state_t state;
	rec_addr_t  addr;
	logic       running;
	logic       start;
	logic       stop;
	logic       capture;

	assign running = state == REC_RUNNING;

	always_comb begin
		start   = (|(ctl.start_routes & route)) || ctl.start_now;
		stop    = (|(ctl.stop_routes & route)) || ctl.stop_now;
		capture = running && ((|(ctl.cap_routes & route)) || ctl.cap_now);

		// memory full in one-shot mode.
		if (running && !ctl.cyclic && &addr)
			stop = 1'b1;

		// start and stop together act as a toggle.
		if (running)
			start = 1'b0;
		if (!running)
			stop = 1'b0;

		// last entry carries the stop flag.
		if (stop)
			capture = 1'b1;
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			state <= REC_IDLE;
		end else if (start) begin
			state <= REC_RUNNING;
		end else if (stop) begin
			state <= REC_IDLE;
		end
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			addr <= '0;
		end else if (ctl.addr_load) begin
			addr <= ctl.addr_val;
		end else if (capture) begin
			addr <= addr + 1'b1;
		end
	end

	always_ff @(posedge pllclk) begin
		if (capture)
			mem[addr] <= {stop, 1'b0, sample};
		ctl.rd_word <= mem[ctl.rd_idx];
	end

	assign ctl.running = running;
	assign ctl.addr    = addr;

endmodule

// ==== hw/probe_regs.sv ====
`timescale 1ns/1ps

module probe_regs #(
	parameter int NUM_COMPARATORS = 2
) (
	input  logic                     pllclk,
	input  logic                     f_reset,
	input  bus_probe_pkg::reg_addr_t paddr,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  bus_probe_pkg::byte_t     pwdata,
	input  bus_probe_pkg::sample_t   sample,
	output bus_probe_pkg::byte_t     prdata,
	output logic                     pready,
	output logic                     pslverr,
	trig_cfg_if.cfg                  trig,
	rec_ctrl_if.cfg                  rec
);
	import bus_probe_pkg::*;

	atom_t     atom;
	atom_t     sample_word;
	reg_addr_t mem_off;
	logic      access;
	logic      mem_wait;
	logic      wr_done;
	logic      mapped;
	logic      sel_mem;
	logic      sel_atom;
	logic      sel_ones;
	logic      sel_ctl;
	logic      sel_cfg;
	logic      sel_stat;
	logic      sel_adr;
	logic      sel_cmp_val;
	logic      sel_cmp_route;
	logic      sel_sample;

	assign mem_off       = paddr - ADDR_REC_RAM;
	assign sel_mem       = paddr < ADDR_REG_BASE;
	assign sel_atom      = paddr[11:2] == ADDR_ATOM[11:2];
	assign sel_ones      = paddr == ADDR_ONES;
	assign sel_ctl       = paddr == ADDR_REC_CTL;
	assign sel_cfg       = paddr == ADDR_REC_CFG;
	assign sel_stat      = paddr == ADDR_REC_STAT;
	assign sel_adr       = paddr[11:1] == ADDR_REC_ADR[11:1];
	assign sel_cmp_val   = paddr == ADDR_CMP_VAL;
	assign sel_cmp_route = paddr == ADDR_CMP_ROUTE;
	assign sel_sample    = paddr[11:2] == ADDR_SAMPLE[11:2];
	assign mapped        = sel_mem || sel_atom || sel_ones || sel_ctl || sel_cfg || sel_stat ||
	                       sel_adr || sel_cmp_val || sel_cmp_route || sel_sample;

	assign access      = psel && penable;
	assign sample_word = atom_t'(sample);
	assign rec.rd_idx  = mem_off[11:2];

	// record memory reads need one extra cycle for the ram output.
	assign pready  = !(access && sel_mem && !pwrite && !mem_wait);
	assign pslverr = access && !mapped;
	assign wr_done = access && pready && pwrite && mapped;

	always_ff @(posedge pllclk) begin
		if (f_reset)
			mem_wait <= 1'b0;
		else
			mem_wait <= access && sel_mem && !pwrite && !mem_wait;
	end

	always_comb begin
		prdata = '0;
		if (sel_mem)
			prdata = rec.rd_word[8*paddr[1:0] +: 8];
		else if (sel_atom)
			prdata = atom[8*paddr[1:0] +: 8];
		else if (sel_cfg)
			prdata = {7'b0, rec.cyclic};
		else if (sel_stat)
			prdata = {7'b0, rec.running};
		else if (sel_adr)
			prdata = paddr[0] ? byte_t'(rec.addr[9:8]) : rec.addr[7:0];
		else if (sel_sample)
			prdata = sample_word[8*paddr[1:0] +: 8];
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			atom             <= '0;
			trig.ones        <= '0;
			trig.cmp_val     <= '0;
			trig.cmp_mask    <= '0;
			trig.lvl_route   <= '0;
			trig.edge_route  <= '0;
			rec.start_routes <= '0;
			rec.stop_routes  <= '0;
			rec.cap_routes   <= '0;
			rec.start_now    <= 1'b0;
			rec.stop_now     <= 1'b0;
			rec.cap_now      <= 1'b0;
			rec.cyclic       <= 1'b0;
			rec.addr_load    <= 1'b0;
			rec.addr_val     <= '0;
		end else begin
			// command pulses last exactly one cycle.
			rec.start_now <= wr_done && sel_ctl && pwdata[3];
			rec.stop_now  <= wr_done && sel_ctl && pwdata[4];
			rec.cap_now   <= wr_done && sel_ctl && pwdata[5];
			rec.addr_load <= wr_done && sel_ctl && pwdata[7];

			if (wr_done && sel_atom)
				atom[8*paddr[1:0] +: 8] <= pwdata;
			if (wr_done && sel_ones)
				trig.ones <= atom[NUM_ROUTES-1:0];
			if (wr_done && sel_cfg)
				rec.cyclic <= pwdata[0];

			if (wr_done && sel_ctl) begin
				if (pwdata[0])
					rec.start_routes <= atom[NUM_ROUTES-1:0];
				if (pwdata[1])
					rec.stop_routes <= atom[NUM_ROUTES-1:0];
				if (pwdata[2])
					rec.cap_routes <= atom[NUM_ROUTES-1:0];
				if (pwdata[7])
					rec.addr_val <= atom[REC_ADDR_W-1:0];
			end

			// low nibble selects value or level route, high nibble mask or edge route.
			for (int i = 0; i < NUM_COMPARATORS; i++) begin
				if (wr_done && sel_cmp_val && pwdata[i])
					trig.cmp_val[i] <= atom[SAMPLE_W-1:0];
				if (wr_done && sel_cmp_val && pwdata[i+4])
					trig.cmp_mask[i] <= atom[SAMPLE_W-1:0];
				if (wr_done && sel_cmp_route && pwdata[i])
					trig.lvl_route[i] <= atom[NUM_ROUTES-1:0];
				if (wr_done && sel_cmp_route && pwdata[i+4])
					trig.edge_route[i] <= atom[NUM_ROUTES-1:0];
			end
		end
	end

endmodule

// ==== hw/bus_probe_top.sv ====
`timescale 1ns/1ps

module bus_probe_top #(
	parameter int NUM_COMPARATORS = 2
) (
	input  logic                     pllclk,
	input  logic                     f_reset,
	input  bus_probe_pkg::reg_addr_t paddr,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  bus_probe_pkg::byte_t     pwdata,
	output bus_probe_pkg::byte_t     prdata,
	output logic                     pready,
	output logic                     pslverr,
	input  logic [14:0]              dut_adr,
	input  logic [7:0]               dut_data,
	input  logic                     n_rd,
	input  logic                     n_wr,
	input  logic                     n_cs_rom,
	input  logic                     n_cs_xram,
	input  logic                     phi,
	input  logic                     n_reset,
	input  logic                     aux_in,
	output bus_probe_pkg::route_t    route
);
	import bus_probe_pkg::*;

	sample_t sample;

	trig_cfg_if #(.NUM_COMPARATORS(NUM_COMPARATORS)) u_trig_cfg ();
	rec_ctrl_if u_rec_ctrl ();

	bus_sampler u_sampler (
		.pllclk, .f_reset,
		.dut_adr, .dut_data, .n_rd, .n_wr, .n_cs_rom, .n_cs_xram,
		.phi, .n_reset, .aux_in,
		.sample
	);

	trigger_unit #(.NUM_COMPARATORS(NUM_COMPARATORS)) u_trigger (
		.pllclk, .f_reset,
		.sample,
		.cfg   (u_trig_cfg.trig),
		.route
	);

	recorder u_recorder (
		.pllclk, .f_reset,
		.sample,
		.route,
		.ctl   (u_rec_ctrl.rec)
	);

	probe_regs #(.NUM_COMPARATORS(NUM_COMPARATORS)) u_regs (
		.pllclk, .f_reset,
		.paddr, .psel, .penable, .pwrite, .pwdata,
		.sample,
		.prdata, .pready, .pslverr,
		.trig  (u_trig_cfg.cfg),
		.rec   (u_rec_ctrl.cfg)
	);

endmodule

// ==== verification/probe_checker.sv ====
`timescale 1ns/1ps

module probe_checker #(
	parameter int NUM_COMPARATORS = 2
) (
	input logic                     pllclk,
	input logic                     f_reset,
	input bus_probe_pkg::reg_addr_t paddr,
	input logic                     psel,
	input logic                     penable,
	input logic                     pwrite,
	input bus_probe_pkg::byte_t     pwdata,
	input bus_probe_pkg::byte_t     prdata,
	input logic                     pready,
	input logic                     pslverr,
	input logic [14:0]              dut_adr,
	input logic [7:0]               dut_data,
	input logic                     n_rd, n_wr, n_cs_rom, n_cs_xram, phi, n_reset, aux_in,
	input bus_probe_pkg::route_t    route
);
	import bus_probe_pkg::*;

	// active-low pins in the sample layout.
	localparam sample_t STROBES = 30'h1700_8000;

	int errors = 0;

	sample_t   s1;
	sample_t   s2;
	sample_t   cmp_val [NUM_COMPARATORS];
	sample_t   cmp_mask [NUM_COMPARATORS];
	route_t    lvl [NUM_COMPARATORS];
	route_t    edg [NUM_COMPARATORS];
	logic [NUM_COMPARATORS-1:0] hit;
	logic [NUM_COMPARATORS-1:0] prev_hit;
	route_t    ones;
	route_t    start_r;
	route_t    stop_r;
	route_t    cap_r;
	route_t    exp_route;
	route_t    route_nx;
	atom_t     atom;
	logic      cyclic;
	logic      running;
	logic      p_start;
	logic      p_stop;
	logic      p_cap;
	logic      p_load;
	rec_addr_t rec_addr;
	rec_addr_t load_val;
	rec_word_t mem [1024];
	logic      go;
	logic      halt;
	logic      grab;
	logic      done;
	logic      exp_ready;
	int        wait_cycles;

	function automatic logic is_mapped(input reg_addr_t a);
		return a < 12'hF00 || (a >= ADDR_ATOM && a <= ADDR_REC_ADR + 1) ||
		       a == ADDR_CMP_VAL || a == ADDR_CMP_ROUTE ||
		       (a >= ADDR_SAMPLE && a <= ADDR_SAMPLE + 3);
	endfunction

	function automatic byte_t expected_read(input reg_addr_t a);
		atom_t w;
		w = '0;
		if (a < 12'hF00)
			w = mem[a[11:2]];
		else if (a >= ADDR_ATOM && a <= ADDR_ATOM + 3)
			w = atom;
		else if (a >= ADDR_SAMPLE && a <= ADDR_SAMPLE + 3)
			w = atom_t'(s2);
		else if (a == ADDR_REC_ADR || a == ADDR_REC_ADR + 1)
			w = atom_t'(rec_addr);
		else if (a == ADDR_REC_CFG)
			return {7'b0, cyclic};
		else if (a == ADDR_REC_STAT)
			return {7'b0, running};
		return w[8*a[1:0] +: 8];
	endfunction

	always @(posedge pllclk) begin
		if (f_reset) begin
			s1          <= '0;
			s2          <= '0;
			cmp_val     <= '{default: '0};
			cmp_mask    <= '{default: '0};
			lvl         <= '{default: '0};
			edg         <= '{default: '0};
			prev_hit    <= '0;
			ones        <= '0;
			start_r     <= '0;
			stop_r      <= '0;
			cap_r       <= '0;
			exp_route   <= '0;
			atom        <= '0;
			cyclic      <= 1'b0;
			running     <= 1'b0;
			p_start     <= 1'b0;
			p_stop      <= 1'b0;
			p_cap       <= 1'b0;
			p_load      <= 1'b0;
			rec_addr    <= '0;
			load_val    <= '0;
			wait_cycles <= 0;
		end else begin
			done = psel && penable && pready;
			if (route !== exp_route) begin
				errors++;
				$display("FAIL route: got %h expected %h", route, exp_route);
			end

			// memory reads wait exactly one access cycle.
			exp_ready = !(psel && penable && !pwrite && paddr < 12'hF00) || wait_cycles == 1;
			if (pready !== exp_ready) begin
				errors++;
				$display("FAIL pready @%h: got %h expected %h", paddr, pready, exp_ready);
			end
			if (psel && penable && !pready)
				wait_cycles <= wait_cycles + 1;
			else
				wait_cycles <= 0;

			if (done && pslverr !== !is_mapped(paddr)) begin
				errors++;
				$display("FAIL pslverr @%h: got %h expected %h", paddr, pslverr, !is_mapped(paddr));
			end
			if (done && !pwrite && prdata !== expected_read(paddr)) begin
				errors++;
				$display("FAIL prdata @%h: got %h expected %h", paddr, prdata,
				         expected_read(paddr));
			end

			// two sync stages with the strobes turned active high.
			s1 <= {aux_in, n_reset, phi, n_wr, n_rd, n_cs_xram, dut_data, n_cs_rom, dut_adr} ^
			      STROBES;
			s2 <= s1;

			route_nx = ones;
			for (int i = 0; i < NUM_COMPARATORS; i++) begin
				hit[i] = ((s2 ^ cmp_val[i]) & cmp_mask[i]) == '0;
				if (hit[i])
					route_nx |= lvl[i];
				if (hit[i] && !prev_hit[i])
					route_nx |= edg[i];
			end
			exp_route <= route_nx;
			prev_hit  <= hit;

			// a full one-shot memory ends the run.
			go   = !running && (p_start || (|(start_r & exp_route)));
			halt = running && (p_stop || (|(stop_r & exp_route)) || (!cyclic && &rec_addr));
			grab = running && (halt || p_cap || (|(cap_r & exp_route)));
			if (go)
				running <= 1'b1;
			else if (halt)
				running <= 1'b0;
			if (grab)
				mem[rec_addr] <= {halt, 1'b0, s2};
			if (p_load)
				rec_addr <= load_val;
			else if (grab)
				rec_addr <= rec_addr + 1'b1;

			p_start <= done && pwrite && paddr == ADDR_REC_CTL && pwdata[3];
			p_stop  <= done && pwrite && paddr == ADDR_REC_CTL && pwdata[4];
			p_cap   <= done && pwrite && paddr == ADDR_REC_CTL && pwdata[5];
			p_load  <= done && pwrite && paddr == ADDR_REC_CTL && pwdata[7];

			if (done && pwrite && is_mapped(paddr)) begin
				if (paddr >= ADDR_ATOM && paddr <= ADDR_ATOM + 3)
					atom[8*paddr[1:0] +: 8] <= pwdata;
				if (paddr == ADDR_ONES)
					ones <= atom[NUM_ROUTES-1:0];
				if (paddr == ADDR_REC_CFG)
					cyclic <= pwdata[0];
				if (paddr == ADDR_REC_CTL) begin
					if (pwdata[0])
						start_r <= atom[NUM_ROUTES-1:0];
					if (pwdata[1])
						stop_r <= atom[NUM_ROUTES-1:0];
					if (pwdata[2])
						cap_r <= atom[NUM_ROUTES-1:0];
					if (pwdata[7])
						load_val <= atom[REC_ADDR_W-1:0];
				end
				for (int i = 0; i < NUM_COMPARATORS; i++) begin
					if (paddr == ADDR_CMP_VAL && pwdata[i])
						cmp_val[i] <= atom[SAMPLE_W-1:0];
					if (paddr == ADDR_CMP_VAL && pwdata[i+4])
						cmp_mask[i] <= atom[SAMPLE_W-1:0];
					if (paddr == ADDR_CMP_ROUTE && pwdata[i])
						lvl[i] <= atom[NUM_ROUTES-1:0];
					if (paddr == ADDR_CMP_ROUTE && pwdata[i+4])
						edg[i] <= atom[NUM_ROUTES-1:0];
				end
			end
		end
	end

endmodule

// ==== verification/tb_bus_probe.sv ====
`timescale 1ns/1ps

module tb_bus_probe;
	import bus_probe_pkg::*;

	localparam int NUM_COMPARATORS = 2;
	// active-low strobe positions in the sample word.
	localparam logic [29:0] INV_BITS = 30'h1700_8000;

	logic        pllclk;
	logic        f_reset;
	reg_addr_t   paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	byte_t       pwdata;
	byte_t       prdata;
	logic        pready;
	logic        pslverr;
	logic [14:0] dut_adr;
	logic [7:0]  dut_data;
	logic        n_rd, n_wr, n_cs_rom, n_cs_xram, phi, n_reset, aux_in;
	route_t      route;
	logic [31:0] rng_state = 32'd37;
	int          timeouts = 0;

	bus_probe_top #(.NUM_COMPARATORS(NUM_COMPARATORS)) u_dut (.*);

	probe_checker #(.NUM_COMPARATORS(NUM_COMPARATORS)) u_chk (.*);

	initial begin
		pllclk = 1'b0;
		forever #10 pllclk = ~pllclk;
	end

	function logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic apb_xfer(input logic wr, input reg_addr_t a, input byte_t d);
		int n;
		@(posedge pllclk);
		paddr   <= a;
		pwrite  <= wr;
		pwdata  <= d;
		psel    <= 1'b1;
		penable <= 1'b0;
		@(posedge pllclk);
		penable <= 1'b1;
		n = 0;
		@(posedge pllclk);
		while (!pready && n < 16) begin
			n++;
			@(posedge pllclk);
		end
		if (!pready) begin
			timeouts++;
			$display("timeout: pready stayed low at address %h", a);
		end
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input reg_addr_t a, input byte_t d);
		apb_xfer(1'b1, a, d);
	endtask

	task automatic apb_read(input reg_addr_t a);
		apb_xfer(1'b0, a, 8'h00);
	endtask

	task automatic load_atom(input logic [31:0] v);
		for (int i = 0; i < 4; i++)
			apb_write(reg_addr_t'(ADDR_ATOM + i), v[8*i +: 8]);
	endtask

	task automatic read_entry(input int idx);
		for (int b = 0; b < 4; b++)
			apb_read(reg_addr_t'(idx * 4 + b));
	endtask

	// raw pin levels in sample bit order.
	task automatic hold_pins(input logic [29:0] r, input int cycles);
		@(posedge pllclk);
		dut_adr   <= r[14:0];
		n_cs_rom  <= r[15];
		dut_data  <= r[23:16];
		n_cs_xram <= r[24];
		n_rd      <= r[25];
		n_wr      <= r[26];
		phi       <= r[27];
		n_reset   <= r[28];
		aux_in    <= r[29];
		repeat (cycles) @(posedge pllclk);
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] val;
		logic [31:0] mask;
		int          base;
		int          n_cap;
		f_reset   = 1'b1;
		paddr     = '0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		pwdata    = '0;
		dut_adr   = '0;
		dut_data  = '0;
		n_rd      = 1'b1;
		n_wr      = 1'b1;
		n_cs_rom  = 1'b1;
		n_cs_xram = 1'b1;
		phi       = 1'b0;
		n_reset   = 1'b1;
		aux_in    = 1'b0;
		repeat (8) @(posedge pllclk);
		f_reset <= 1'b0;

		// readback of atom, cyclic bit, record address and unmapped space.
		load_atom(xorshift32());
		for (int i = 0; i < 4; i++)
			apb_read(reg_addr_t'(ADDR_ATOM + i));
		apb_write(ADDR_REC_CFG, 8'h01);
		apb_read(ADDR_REC_CFG);
		load_atom(xorshift32());
		apb_write(ADDR_REC_CTL, 8'h80);
		apb_read(ADDR_REC_ADR);
		apb_read(reg_addr_t'(ADDR_REC_ADR + 1));
		apb_write(12'hF30, 8'hFF);
		apb_read(12'hF30);
		apb_read(12'hF0C);
		apb_read(12'hF54);

		// live sample bytes on held pins.
		repeat (8) begin
			r = xorshift32();
			hold_pins(r[29:0], 4);
			for (int b = 0; b < 4; b++)
				apb_read(reg_addr_t'(ADDR_SAMPLE + b));
		end

		// always-on routes.
		r = xorshift32();
		apb_write(ADDR_ATOM, {2'b00, r[5:0]} | 8'h01);
		apb_write(ADDR_ONES, 8'h00);
		repeat (4) @(posedge pllclk);
		apb_write(ADDR_ATOM, 8'h00);
		apb_write(ADDR_ONES, 8'h00);
		repeat (4) @(posedge pllclk);

		// comparator 0 drives level on route bit 0 and edge on bit 1.
		val  = xorshift32();
		mask = xorshift32() & xorshift32() & xorshift32();
		load_atom(val);
		apb_write(ADDR_CMP_VAL, 8'h01);
		load_atom(mask);
		apb_write(ADDR_CMP_VAL, 8'h10);
		load_atom(32'h1);
		apb_write(ADDR_CMP_ROUTE, 8'h01);
		load_atom(32'h2);
		apb_write(ADDR_CMP_ROUTE, 8'h10);
		repeat (24) begin
			r = xorshift32();
			// about half the steps force the masked bits to match.
			if (r[31])
				r[29:0] = (r[29:0] & ~mask[29:0]) | ((val[29:0] ^ INV_BITS) & mask[29:0]);
			hold_pins(r[29:0], 4);
		end

		// start, n captures, stop, then read the entries back.
		r     = xorshift32();
		base  = r[9:0] % 800;
		n_cap = 3 + r[17:16];
		load_atom(base);
		apb_write(ADDR_REC_CTL, 8'h80);
		apb_write(ADDR_REC_CTL, 8'h08);
		repeat (n_cap) begin
			r = xorshift32();
			hold_pins(r[29:0], 4);
			apb_write(ADDR_REC_CTL, 8'h20);
		end
		r = xorshift32();
		hold_pins(r[29:0], 4);
		apb_write(ADDR_REC_CTL, 8'h10);
		repeat (2) @(posedge pllclk);
		apb_read(ADDR_REC_STAT);
		for (int k = 0; k <= n_cap; k++)
			read_entry(base + k);
		apb_read(ADDR_REC_ADR);
		apb_read(reg_addr_t'(ADDR_REC_ADR + 1));

		// one-shot mode stops itself at the last entry.
		apb_write(ADDR_REC_CFG, 8'h00);
		load_atom(32'd1022);
		apb_write(ADDR_REC_CTL, 8'h80);
		apb_write(ADDR_REC_CTL, 8'h08);
		apb_write(ADDR_REC_CTL, 8'h20);
		repeat (3) @(posedge pllclk);
		apb_read(ADDR_REC_STAT);
		apb_read(ADDR_REC_ADR);
		apb_read(reg_addr_t'(ADDR_REC_ADR + 1));
		// entry 1023 sits under the register block, so this read is unmapped.
		apb_read(12'hFFC);

		repeat (4) @(posedge pllclk);
		$display("checker errors %0d, timeouts %0d", u_chk.errors, timeouts);
		if (u_chk.errors == 0 && timeouts == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== list.f ====
hw/bus_probe_pkg.sv
hw/trig_cfg_if.sv
hw/rec_ctrl_if.sv
hw/bus_sampler.sv
hw/trigger_unit.sv
hw/recorder.sv
hw/probe_regs.sv
hw/bus_probe_top.sv
verification/probe_checker.sv
verification/tb_bus_probe.sv

// ==== Bender.yml ====
package:
  name: bus_probe

sources:
  - hw/bus_probe_pkg.sv
  - hw/trig_cfg_if.sv
  - hw/rec_ctrl_if.sv
  - hw/bus_sampler.sv
  - hw/trigger_unit.sv
  - hw/recorder.sv
  - hw/probe_regs.sv
  - hw/bus_probe_top.sv
  - target: test
    files:
      - verification/probe_checker.sv
      - verification/tb_bus_probe.sv
